//--- wbsys.f
+incdir+testbench
hdl/wbsys_pkg.sv
hdl/wbsys_lsu_timer.sv
hdl/wbsys_ex_wb_reg.sv
hdl/wbsys_lsu.sv
hdl/wbsys_wb_stage.sv
hdl/wbsys_ctrl_fsm.sv
hdl/wbsys_regfile.sv
hdl/wbsys_top.sv
testbench/wbsys_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = wbsys_tb
FILELIST = wbsys.f
BUILD    = obj_dir
PASS_MSG = Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- testbench/wbsys_tb_table.svh
`ifndef WBSYS_TB_TABLE_SVH
`define WBSYS_TB_TABLE_SVH

  // Columns: kind, target reg, ALU result or store data, byte address, latency,
  // watchpoint enable, halt hold, expected target reg value, expected trap

  typedef enum logic [1:0] {
    OP_ALU,
    OP_LOAD,
    OP_STORE
  } op_kind_e;

  typedef enum logic [1:0] {
    NO_TRAP,
    MPU_TRAP,
    WPT_TRAP
  } exp_trap_e;

  typedef struct packed {
    op_kind_e            kind;
    wbsys_pkg::rf_addr_t rd;
    wbsys_pkg::word_t    wdata;
    wbsys_pkg::word_t    addr;
    logic [1:0]          lat;
    logic                wpt;
    logic                hold;
    wbsys_pkg::word_t    exp_rd;
    exp_trap_e           exp_trap;
  } row_t;

  localparam int NUM_ROWS = 17;

  // Watchpoint address for the watchpoint rows
  localparam wbsys_pkg::word_t WPT_ADDR = 32'h0000_0040;

  localparam row_t ROWS [NUM_ROWS] = '{
    // ALU writes, x0 stays zero
    '{OP_ALU,   5'd1, 32'h1234_5678, 32'h0000_0000, 2'd0, 1'b0, 1'b0, 32'h1234_5678, NO_TRAP},
    '{OP_ALU,   5'd0, 32'hdead_beef, 32'h0000_0000, 2'd0, 1'b0, 1'b0, 32'h0000_0000, NO_TRAP},
    // Store then load at each latency
    '{OP_STORE, 5'd1, 32'ha5a5_0000, 32'h0000_0010, 2'd0, 1'b0, 1'b0, 32'h1234_5678, NO_TRAP},
    '{OP_LOAD,  5'd2, 32'h0000_0000, 32'h0000_0010, 2'd0, 1'b0, 1'b0, 32'ha5a5_0000, NO_TRAP},
    '{OP_STORE, 5'd1, 32'ha5a5_0001, 32'h0000_0014, 2'd1, 1'b0, 1'b0, 32'h1234_5678, NO_TRAP},
    '{OP_LOAD,  5'd3, 32'h0000_0000, 32'h0000_0014, 2'd1, 1'b0, 1'b0, 32'ha5a5_0001, NO_TRAP},
    '{OP_STORE, 5'd1, 32'ha5a5_0002, 32'h0000_0018, 2'd2, 1'b0, 1'b0, 32'h1234_5678, NO_TRAP},
    '{OP_LOAD,  5'd4, 32'h0000_0000, 32'h0000_0018, 2'd2, 1'b0, 1'b0, 32'ha5a5_0002, NO_TRAP},
    '{OP_STORE, 5'd1, 32'ha5a5_0003, 32'h0000_001c, 2'd3, 1'b0, 1'b0, 32'h1234_5678, NO_TRAP},
    '{OP_LOAD,  5'd5, 32'h0000_0000, 32'h0000_001c, 2'd3, 1'b0, 1'b0, 32'ha5a5_0003, NO_TRAP},
    // Out of range loads, target keeps its old value
    '{OP_LOAD,  5'd2, 32'h0000_0000, 32'h0000_0100, 2'd1, 1'b0, 1'b0, 32'ha5a5_0000, MPU_TRAP},
    '{OP_LOAD,  5'd3, 32'h0000_0000, 32'hffff_fffc, 2'd3, 1'b0, 1'b0, 32'ha5a5_0001, MPU_TRAP},
    // Watchpoint store is dropped, later load sees the first value
    '{OP_STORE, 5'd1, 32'hcafe_f00d, 32'h0000_0040, 2'd0, 1'b0, 1'b0, 32'h1234_5678, NO_TRAP},
    '{OP_STORE, 5'd1, 32'h0bad_0bad, 32'h0000_0040, 2'd2, 1'b1, 1'b0, 32'h1234_5678, WPT_TRAP},
    '{OP_LOAD,  5'd6, 32'h0000_0000, 32'h0000_0040, 2'd1, 1'b0, 1'b0, 32'hcafe_f00d, NO_TRAP},
    // Ops held in write-back by a halt
    '{OP_ALU,   5'd7, 32'h7777_0007, 32'h0000_0000, 2'd0, 1'b0, 1'b1, 32'h7777_0007, NO_TRAP},
    '{OP_LOAD,  5'd8, 32'h0000_0000, 32'h0000_0014, 2'd2, 1'b0, 1'b1, 32'ha5a5_0001, NO_TRAP}
  };

`endif

//--- testbench/wbsys_tb.sv
module wbsys_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS    = 64;
  localparam int NUM_REGS     = 32;
  localparam int RESET_CYCLES = 16;

  `include "wbsys_tb_table.svh"

  // Budget of 20 cycles per row on top of reset
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 20 + RESET_CYCLES;

  logic                 clk;
  logic                 rst_n;
  logic                 issue_valid;
  wbsys_pkg::issue_op_t issue_op;
  logic                 issue_ready;
  logic                 halt;
  logic                 wpt_en;
  wbsys_pkg::word_t     wpt_addr;
  wbsys_pkg::rf_addr_t  rd_addr;
  wbsys_pkg::word_t     rd_data;
  logic                 retire;
  logic                 trap;
  wbsys_pkg::trap_t     trap_info;

  int   errors;
  int   checks;
  int   retire_cnt;
  int   trap_cnt;
  int   row_idx;
  logic row_err;

  wbsys_top #(
    .MEM_WORDS (MEM_WORDS),
    .NUM_REGS  (NUM_REGS)
  ) i_wbsys_top (
    .clk (clk), .rst_n (rst_n), .issue_valid_i (issue_valid), .issue_op_i (issue_op),
    .issue_ready_o (issue_ready), .halt_i (halt), .wpt_en_i (wpt_en), .wpt_addr_i (wpt_addr),
    .rd_addr_i (rd_addr), .rd_data_o (rd_data), .retire_o (retire), .trap_o (trap),
    .trap_info_o (trap_info)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Strobe counters, sampled away from the driving edge
  always @(negedge clk) begin
    if (rst_n && retire) begin
      retire_cnt = retire_cnt + 1;
    end
    if (rst_n && trap) begin
      trap_cnt = trap_cnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks and op builder
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input wbsys_pkg::word_t exp,
                            input wbsys_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      row_err = 1'b1;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_trap(input string name, input wbsys_pkg::trap_t exp,
                            input wbsys_pkg::trap_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      row_err = 1'b1;
      $display("ERR %0t %s expected cause %0d addr %h actual cause %0d addr %h",
               $time, name, exp.cause, exp.mem_addr, act.cause, act.mem_addr);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      row_err = 1'b1;
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // Issue payload for one table row
  function automatic wbsys_pkg::issue_op_t build_op(input row_t r);
    wbsys_pkg::issue_op_t op;
    op.lsu_en   = (r.kind != OP_ALU);
    op.lsu_we   = (r.kind == OP_STORE);
    op.rf_we    = (r.kind != OP_STORE);
    op.rf_waddr = r.rd;
    op.rf_wdata = r.wdata;
    op.mem_addr = r.addr;
    op.lat      = r.lat;
    return op;
  endfunction

  ////////////////////////////////////////////////////////////
  // Table loop
  ////////////////////////////////////////////////////////////

  initial begin
    wbsys_pkg::trap_t exp_trap;
    int               retire_start;
    int               trap_start;
    int               halt_cycles;
    void'($urandom(37));
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue_op    = '0;
    halt        = 1'b0;
    wpt_en      = 1'b0;
    wpt_addr    = WPT_ADDR;
    rd_addr     = '0;
    errors      = 0;
    checks      = 0;
    retire_cnt  = 0;
    trap_cnt    = 0;
    row_idx     = 0;
    row_err     = 1'b0;
    // Reset values, seen just before release
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_flag("issue_ready_o", 1'b1, issue_ready);
    check_flag("retire_o", 1'b0, retire);
    check_flag("trap_o", 1'b0, trap);
    @(posedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_idx = r;
      row_err = 1'b0;
      @(posedge clk);
      retire_start = retire_cnt;
      trap_start   = trap_cnt;
      issue_valid <= 1'b1;
      issue_op    <= build_op(ROWS[r]);
      wpt_en      <= ROWS[r].wpt;
      // Ready seen at the negedge means transfer on the next rising edge
      do begin
        @(negedge clk);
      end while (issue_ready !== 1'b1);
      @(posedge clk);
      issue_valid <= 1'b0;
      if (ROWS[r].hold) begin
        halt_cycles = 1 + int'($urandom % 8);
        halt <= 1'b1;
        repeat (halt_cycles) begin
          @(negedge clk);
          check_flag("issue_ready_o", 1'b0, issue_ready);
          check_flag("retire_o", 1'b0, retire);
        end
        @(posedge clk);
        halt <= 1'b0;
      end
      do begin
        @(negedge clk);
      end while (retire !== 1'b1);
      check_flag("trap_o", ROWS[r].exp_trap != NO_TRAP, trap);
      if (ROWS[r].exp_trap != NO_TRAP) begin
        exp_trap.cause    = (ROWS[r].exp_trap == WPT_TRAP) ? wbsys_pkg::CAUSE_WPT :
                                                             wbsys_pkg::CAUSE_MPU;
        exp_trap.mem_addr = ROWS[r].addr;
        check_trap("trap_info_o", exp_trap, trap_info);
      end
      // Register write lands on this edge
      @(posedge clk);
      rd_addr <= ROWS[r].rd;
      @(posedge clk);
      check_word("retire_o count", 32'd1, wbsys_pkg::word_t'(retire_cnt - retire_start));
      check_word("trap_o count", (ROWS[r].exp_trap != NO_TRAP) ? 32'd1 : 32'd0,
                 wbsys_pkg::word_t'(trap_cnt - trap_start));
      @(negedge clk);
      check_word("rd_data_o", ROWS[r].exp_rd, rd_data);
      $display("row %0d %s x%0d: %s", r, ROWS[r].kind.name(), ROWS[r].rd,
               row_err ? "mismatch" : "ok");
    end
    $display("Rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog on the whole run
  initial begin
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles in row %0d, the DUT stopped responding",
             cycle_cnt, row_idx);
    $display("Test failed");
    $finish;
  end

endmodule

//--- hdl/wbsys_top.sv
module wbsys_top #(
  parameter int MEM_WORDS = 64,
  parameter int NUM_REGS  = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // Issue port
  input  logic                 issue_valid_i,
  input  wbsys_pkg::issue_op_t issue_op_i,
  output logic                 issue_ready_o,
  // Control and watchpoint
  input  logic                 halt_i,
  input  logic                 wpt_en_i,
  input  wbsys_pkg::word_t     wpt_addr_i,
  // Register observation
  input  wbsys_pkg::rf_addr_t  rd_addr_i,
  output wbsys_pkg::word_t     rd_data_o,
  // Retire and trap reporting
  output logic                 retire_o,
  output logic                 trap_o,
  output wbsys_pkg::trap_t     trap_info_o
);

  wbsys_pkg::ex_wb_pipe_t ex_wb_pipe;
  wbsys_pkg::lsu_resp_t   lsu_resp;
  wbsys_pkg::ctrl_fsm_t   ctrl_fsm;
  wbsys_pkg::rf_addr_t    rf_waddr;
  wbsys_pkg::word_t       rf_wdata;
  wbsys_pkg::mpu_status_e mpu_status;
  logic                   lsu_req;
  logic                   rf_we;
  logic                   wb_ready;
  logic                   wb_valid;
  logic                   abort_op;
  logic                   wpt_match;
  logic                   issue_en;

  // Write-back ready, gated by the controller
  assign issue_ready_o = wb_ready && issue_en;

  wbsys_ex_wb_reg i_ex_wb_reg (
    .clk (clk), .rst_n (rst_n), .issue_valid_i (issue_valid_i), .issue_op_i (issue_op_i),
    .wb_ready_i (issue_ready_o), .ctrl_fsm_i (ctrl_fsm), .ex_wb_pipe_o (ex_wb_pipe)
  );

  wbsys_lsu #(.MEM_WORDS (MEM_WORDS)) i_lsu (
    .clk (clk), .rst_n (rst_n), .ex_wb_pipe_i (ex_wb_pipe), .req_i (lsu_req),
    .wpt_en_i (wpt_en_i), .wpt_addr_i (wpt_addr_i), .resp_o (lsu_resp)
  );

  wbsys_wb_stage i_wb_stage (
    .clk (clk), .rst_n (rst_n), .ex_wb_pipe_i (ex_wb_pipe), .ctrl_fsm_i (ctrl_fsm),
    .lsu_resp_i (lsu_resp), .lsu_req_o (lsu_req), .rf_we_o (rf_we), .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata), .wb_ready_o (wb_ready), .wb_valid_o (wb_valid),
    .abort_op_o (abort_op), .mpu_status_o (mpu_status), .wpt_match_o (wpt_match)
  );

  wbsys_ctrl_fsm i_ctrl_fsm (
    .clk (clk), .rst_n (rst_n), .halt_i (halt_i), .wb_valid_i (wb_valid),
    .abort_op_i (abort_op), .mpu_status_i (mpu_status), .wpt_match_i (wpt_match),
    .mem_addr_i (ex_wb_pipe.op.mem_addr), .ctrl_fsm_o (ctrl_fsm), .issue_en_o (issue_en),
    .retire_o (retire_o), .trap_o (trap_o), .trap_info_o (trap_info_o)
  );

  wbsys_regfile #(.NUM_REGS (NUM_REGS)) i_regfile (
    .clk (clk), .rst_n (rst_n), .we_i (rf_we), .waddr_i (rf_waddr), .wdata_i (rf_wdata),
    .raddr_i (rd_addr_i), .rdata_o (rd_data_o)
  );

endmodule

//--- hdl/wbsys_regfile.sv
module wbsys_regfile #(
  parameter int NUM_REGS = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  // Write port
  input  logic                we_i,
  input  wbsys_pkg::rf_addr_t waddr_i,
  input  wbsys_pkg::word_t    wdata_i,
  // Observation read port
  input  wbsys_pkg::rf_addr_t raddr_i,
  output wbsys_pkg::word_t    rdata_o
);

  wbsys_pkg::word_t regs [NUM_REGS];

  always_ff @(posedge clk, negedge rst_n) begin
    if (rst_n == 1'b0) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Register 0 is hardwired, writes dropped
      if (we_i && (waddr_i != '0) && (int'(waddr_i) < NUM_REGS)) begin
        regs[waddr_i] <= wdata_i;
      end
    end
  end

  // Combinational read
  always_comb begin
    if ((raddr_i == '0) || (int'(raddr_i) >= NUM_REGS)) begin
      rdata_o = '0;
    end else begin
      rdata_o = regs[raddr_i];
    end
  end

endmodule

//--- hdl/wbsys_ctrl_fsm.sv
module wbsys_ctrl_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   halt_i,
  // Write-back status
  input  logic                   wb_valid_i,
  input  logic                   abort_op_i,
  input  wbsys_pkg::mpu_status_e mpu_status_i,
  input  logic                   wpt_match_i,
  input  wbsys_pkg::word_t       mem_addr_i,
  // Commands
  output wbsys_pkg::ctrl_fsm_t   ctrl_fsm_o,
  output logic                   issue_en_o,
  // Reporting
  output logic                   retire_o,
  output logic                   trap_o,
  output wbsys_pkg::trap_t       trap_info_o
);

  typedef enum logic [1:0] {
    RUN   = 2'd0,
    HALT  = 2'd1,
    FLUSH = 2'd2
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        abort;

  // Aborting op retires in this cycle
  assign abort = wb_valid_i && abort_op_i;

  ////////////////////////////////////////////////////////////
  // State register and next state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (rst_n == 1'b0) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        // Abort wins over a halt request
        if (abort) begin
          state_d = FLUSH;
        end else if (halt_i) begin
          state_d = HALT;
        end
      end
      HALT: begin
        if (!halt_i) begin
          state_d = RUN;
        end
      end
      FLUSH: begin
        // Single flush cycle
        state_d = halt_i ? HALT : RUN;
      end
      default: state_d = RUN;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Halt takes effect in the cycle halt_i rises
  assign ctrl_fsm_o.halt_wb = halt_i || (state_q == HALT);
  assign ctrl_fsm_o.kill_wb = (state_q == FLUSH);

  // Keep new ops out while halting, flushing or aborting
  assign issue_en_o = (state_q == RUN) && !halt_i && !abort;

  assign retire_o = wb_valid_i;
  assign trap_o   = abort;

  // MPU fault has priority over a watchpoint hit
  assign trap_info_o.cause = (wpt_match_i && (mpu_status_i == wbsys_pkg::MPU_OK)) ?
                             wbsys_pkg::CAUSE_WPT : wbsys_pkg::CAUSE_MPU;
  assign trap_info_o.mem_addr = mem_addr_i;

endmodule

//--- hdl/wbsys_wb_stage.sv
module wbsys_wb_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // EX/WB pipeline
  input  wbsys_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  // Controller
  input  wbsys_pkg::ctrl_fsm_t   ctrl_fsm_i,
  // LSU
  input  wbsys_pkg::lsu_resp_t   lsu_resp_i,
  output logic                   lsu_req_o,
  // Register file write
  output logic                   rf_we_o,
  output wbsys_pkg::rf_addr_t    rf_waddr_o,
  output wbsys_pkg::word_t       rf_wdata_o,
  // Stage handshake
  output logic                   wb_ready_o,
  output logic                   wb_valid_o,
  output logic                   abort_op_o,
  // Sticky status
  output wbsys_pkg::mpu_status_e mpu_status_o,
  output logic                   wpt_match_o
);

  logic                   instr_valid;
  logic                   lsu_op;
  logic                   lsu_exception;
  logic                   wb_valid;

  // Sticky copies of the one-cycle LSU response
  logic                   lsu_valid_q;
  wbsys_pkg::mpu_status_e lsu_mpu_status_q;
  logic                   lsu_wpt_match_q;

  logic                   lsu_valid;
  wbsys_pkg::mpu_status_e lsu_mpu_status;
  logic                   lsu_wpt_match;

  // Halt or kill hides the op from write-back
  assign instr_valid = ex_wb_pipe_i.instr_valid && !ctrl_fsm_i.kill_wb && !ctrl_fsm_i.halt_wb;
  assign lsu_op      = ex_wb_pipe_i.op.lsu_en;

  ////////////////////////////////////////////////////////////
  // Sticky LSU status
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (rst_n == 1'b0) begin
      lsu_valid_q      <= 1'b0;
      lsu_mpu_status_q <= wbsys_pkg::MPU_OK;
      lsu_wpt_match_q  <= 1'b0;
    end else begin
      if (wb_valid || ctrl_fsm_i.kill_wb) begin
        // Op left write-back
        lsu_valid_q      <= 1'b0;
        lsu_mpu_status_q <= wbsys_pkg::MPU_OK;
        lsu_wpt_match_q  <= 1'b0;
      end else if (lsu_resp_i.valid) begin
        // Response arrived during a halt
        lsu_valid_q      <= 1'b1;
        lsu_mpu_status_q <= lsu_resp_i.mpu_status;
        lsu_wpt_match_q  <= lsu_resp_i.wpt_match;
      end
    end
  end

  assign lsu_valid      = lsu_valid_q ? 1'b1             : lsu_resp_i.valid;
  assign lsu_mpu_status = lsu_valid_q ? lsu_mpu_status_q : lsu_resp_i.mpu_status;
  assign lsu_wpt_match  = lsu_valid_q ? lsu_wpt_match_q  : lsu_resp_i.wpt_match;

  assign lsu_exception = (lsu_mpu_status != wbsys_pkg::MPU_OK);

  ////////////////////////////////////////////////////////////
  // Register write and stage status
  ////////////////////////////////////////////////////////////

  // Non-LSU ops done at once, LSU ops on their response
  assign wb_valid   = (!lsu_op || lsu_valid) && instr_valid;
  assign wb_valid_o = wb_valid;

  // No register write on fault or watchpoint hit
  assign rf_we_o    = ex_wb_pipe_i.op.rf_we && !lsu_exception && !lsu_wpt_match && wb_valid;
  assign rf_waddr_o = ex_wb_pipe_i.op.rf_waddr;
  assign rf_wdata_o = lsu_op ? lsu_resp_i.rdata : ex_wb_pipe_i.op.rf_wdata;

  // Request held until the response is seen, never under kill
  assign lsu_req_o = lsu_op && ex_wb_pipe_i.instr_valid && !ctrl_fsm_i.kill_wb && !lsu_valid_q;

  // Stalled by a pending memory response or a halt
  assign wb_ready_o = ctrl_fsm_i.kill_wb ||
                      ((!(ex_wb_pipe_i.instr_valid && lsu_op) || lsu_valid) &&
                       !ctrl_fsm_i.halt_wb);

  assign abort_op_o   = lsu_op && (lsu_exception || lsu_wpt_match);
  assign mpu_status_o = lsu_mpu_status;
  assign wpt_match_o  = lsu_wpt_match;

endmodule

//--- hdl/wbsys_lsu.sv
module wbsys_lsu #(
  parameter int MEM_WORDS = 64
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Operation in write-back
  input  wbsys_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  // Request strobe from write-back
  input  logic                   req_i,
  // Watchpoint setting
  input  logic                   wpt_en_i,
  input  wbsys_pkg::word_t       wpt_addr_i,
  // Response to write-back
  output wbsys_pkg::lsu_resp_t   resp_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam wbsys_pkg::word_t MEM_BYTES = wbsys_pkg::word_t'(MEM_WORDS * 4);

  wbsys_pkg::word_t mem [MEM_WORDS];

  logic [IDX_W-1:0] idx;
  logic             done;
  logic             out_of_range;
  logic             wpt_hit;
  logic             store_ok;

  ////////////////////////////////////////////////////////////
  // Response timing
  ////////////////////////////////////////////////////////////

  // One timed response per request
  wbsys_lsu_timer i_lsu_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (req_i),
    .lat_i   (ex_wb_pipe_i.op.lat),
    .done_o  (done)
  );

  ////////////////////////////////////////////////////////////
  // Address checks
  ////////////////////////////////////////////////////////////

  // Word index, byte offset dropped
  assign idx = ex_wb_pipe_i.op.mem_addr[IDX_W+1:2];

  // Protection region is the memory itself
  assign out_of_range = (ex_wb_pipe_i.op.mem_addr >= MEM_BYTES);

  // Watchpoint on exact byte address
  assign wpt_hit = wpt_en_i && (ex_wb_pipe_i.op.mem_addr == wpt_addr_i);

  // Store only commits when both checks pass
  assign store_ok = done && ex_wb_pipe_i.op.lsu_en && ex_wb_pipe_i.op.lsu_we &&
                    !out_of_range && !wpt_hit;

  // Checks reported only in the response cycle
  always_comb begin
    resp_o.valid      = done;
    // Read data stays valid while the op sits in write-back
    resp_o.rdata      = mem[idx];
    resp_o.mpu_status = (done && out_of_range) ? wbsys_pkg::MPU_FAULT : wbsys_pkg::MPU_OK;
    resp_o.wpt_match  = done && wpt_hit;
  end

  ////////////////////////////////////////////////////////////
  // Data memory
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (rst_n == 1'b0) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (store_ok) begin
        mem[idx] <= ex_wb_pipe_i.op.rf_wdata;
      end
    end
  end

endmodule

//--- hdl/wbsys_ex_wb_reg.sv
module wbsys_ex_wb_reg (
  input  logic                   clk,
  input  logic                   rst_n,
  // Issue side
  input  logic                   issue_valid_i,
  input  wbsys_pkg::issue_op_t   issue_op_i,
  // Ready from write-back after controller gating
  input  logic                   wb_ready_i,
  input  wbsys_pkg::ctrl_fsm_t   ctrl_fsm_i,
  // To write-back and LSU
  output wbsys_pkg::ex_wb_pipe_t ex_wb_pipe_o
);

  logic                 transfer;
  logic                 instr_valid_q;
  wbsys_pkg::issue_op_t op_q;

  // Handshake completes on valid and ready together
  assign transfer = issue_valid_i && wb_ready_i;

  // Valid bit is the only control state of the register
  always_ff @(posedge clk, negedge rst_n) begin
    if (rst_n == 1'b0) begin
      instr_valid_q <= 1'b0;
    end else begin
      if (ctrl_fsm_i.kill_wb) begin
        // Flush after an abort
        instr_valid_q <= 1'b0;
      end else if (wb_ready_i) begin
        // Write-back done so refill or go empty
        instr_valid_q <= issue_valid_i;
      end
      // Otherwise hold while write-back is busy
    end
  end

  // Operation payload
  always_ff @(posedge clk) begin
    if (transfer) begin
      op_q <= issue_op_i;
    end
  end

  assign ex_wb_pipe_o.instr_valid = instr_valid_q;
  assign ex_wb_pipe_o.op          = op_q;

endmodule

//--- hdl/wbsys_lsu_timer.sv
module wbsys_lsu_timer (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start_i,
  input  logic [1:0] lat_i,
  output logic       done_o
);

  logic [1:0] cnt_q;
  logic       busy_q;

  // Last counting cycle is the response cycle
  assign done_o = busy_q && (cnt_q == 2'd0);

  always_ff @(posedge clk, negedge rst_n) begin
    if (rst_n == 1'b0) begin
      cnt_q  <= 2'd0;
      busy_q <= 1'b0;
    end else begin
      if (busy_q) begin
        // New starts are ignored until the count expires
        if (cnt_q == 2'd0) begin
          busy_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q - 2'd1;
        end
      end else if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= lat_i;
      end
    end
  end

endmodule

//--- hdl/wbsys_pkg.sv
package wbsys_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and basic types
  ////////////////////////////////////////////////////////////

  // Register address width
  parameter int RF_ADDR_W = 5;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [31:0]          word_t;

  // Protection result of a memory access
  typedef enum logic {
    MPU_OK    = 1'b0,
    MPU_FAULT = 1'b1
  } mpu_status_e;

  // Reported trap cause
  typedef enum logic {
    CAUSE_MPU = 1'b0,
    CAUSE_WPT = 1'b1
  } trap_cause_e;

  ////////////////////////////////////////////////////////////
  // Pipeline payloads
  ////////////////////////////////////////////////////////////

  // One decoded operation from the issuer
  typedef struct packed {
    logic       lsu_en;
    logic       lsu_we;    // Store when set, load otherwise
    logic       rf_we;
    rf_addr_t   rf_waddr;
    word_t      rf_wdata;  // ALU result
    word_t      mem_addr;  // Byte address
    logic [1:0] lat;       // Memory response wait
  } issue_op_t;

  // EX/WB register contents
  typedef struct packed {
    logic      instr_valid;
    issue_op_t op;
  } ex_wb_pipe_t;

  // Controller commands to the back end
  typedef struct packed {
    logic halt_wb;
    logic kill_wb;
  } ctrl_fsm_t;

  // LSU response, status fields only meaningful with valid
  typedef struct packed {
    logic        valid;
    word_t       rdata;
    mpu_status_e mpu_status;
    logic        wpt_match;
  } lsu_resp_t;

  // Trap report
  typedef struct packed {
    trap_cause_e cause;
    word_t       mem_addr;
  } trap_t;

endpackage
